//--- decodePkg.sv
// Shared widths, encodings and tables for the bundle decode stage.
// A bundle is a 5-bit template plus three 40-bit slots; bits 127:125 are unused.
// Only templates 0 to 7 are defined, every other template is illegal.
// The template table marks memory slots as LUNIT, the unpacker turns
// them into SUNIT when the store bit is set.
// The decode word is a plain 27-bit vector, field positions are the DW_ constants.
package decodePkg;

	// ==========================================================================
	// Widths and types
	// ==========================================================================
	localparam int INSTR_W = 40;
	localparam int BUNDLE_W = 128;
	localparam int UNIT_W = 3;
	localparam int TEMPLATE_W = 5;
	localparam int RT_W = 7;
	localparam int MEMSZ_W = 3;
	localparam int CONST_W = 64;
	localparam int DW_W = 27;
	localparam int NUM_SLOTS = 3;
	localparam int NUM_TEMPLATES = 8;

	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [BUNDLE_W-1:0] bundle_t;
	typedef logic [UNIT_W-1:0] unit_t;
	typedef logic [TEMPLATE_W-1:0] template_t;
	// Bit 6 selects the float register file
	typedef logic [RT_W-1:0] regTgt_t;
	typedef logic [MEMSZ_W-1:0] memSize_t;
	typedef logic [CONST_W-1:0] const_t;
	typedef logic [DW_W-1:0] decodeWord_t;

	// Execution units
	localparam unit_t NONE = 3'd0;
	localparam unit_t BUNIT = 3'd1;
	localparam unit_t IUNIT = 3'd2;
	localparam unit_t FUNIT = 3'd3;
	localparam unit_t LUNIT = 3'd4;
	localparam unit_t SUNIT = 3'd5;

	// Access sizes, codes 0 to 4 equal the memory op4 low bits
	localparam memSize_t SZ_BYTE = 3'd0;
	localparam memSize_t SZ_WYDE = 3'd1;
	localparam memSize_t SZ_TETRA = 3'd2;
	localparam memSize_t SZ_OCTA = 3'd4;
	localparam memSize_t SZ_DECI = 3'd5;

	// ==========================================================================
	// Instruction and bundle fields
	// ==========================================================================
	localparam int OP4_HI = 9;
	localparam int OP4_LO = 6;
	localparam int RD_HI = 5;
	localparam int RD_LO = 0;
	localparam int RS1_HI = 15;
	localparam int RS1_LO = 10;
	localparam int FUNCT5_HI = 26;
	localparam int FUNCT5_LO = 22;
	localparam int STOREBIT = 34;

	localparam int TEMPLATE_HI = 4;
	localparam int TEMPLATE_LO = 0;
	// Low bit of each slot inside the bundle
	localparam int SLOT_LO [NUM_SLOTS] = '{5, 45, 85};

	// B-unit op4
	localparam logic [3:0] OP_BEQ = 4'd0;
	localparam logic [3:0] OP_BNE = 4'd1;
	localparam logic [3:0] OP_JAL = 4'd2;
	localparam logic [3:0] OP_RET = 4'd3;
	localparam logic [3:0] OP_BLT = 4'd4;
	localparam logic [3:0] OP_BRK = 4'd5;
	localparam logic [3:0] OP_BGE = 4'd6;
	localparam logic [3:0] OP_BBC = 4'd7;
	localparam logic [3:0] OP_RTI = 4'd8;
	localparam logic [3:0] OP_JMP = 4'd9;
	localparam logic [3:0] OP_CHK = 4'd10;
	localparam logic [3:0] OP_CHKI = 4'd11;
	// Variants under OP_RTI, picked by funct5
	localparam logic [4:0] FN_RTI = 5'd0;
	localparam logic [4:0] FN_SEI = 5'd1;
	localparam logic [4:0] FN_WAIT = 5'd2;
	localparam logic [4:0] FN_SYNC = 5'd3;

	// I-unit, F-unit and memory op4
	localparam logic [3:0] OP_R3 = 4'd2;
	localparam logic [3:0] OP_MULI = 4'd12;
	localparam logic [3:0] OP_DIVI = 4'd13;
	localparam logic [3:0] OP_FLT2 = 4'd1;
	localparam logic [4:0] FN_FSYNC = 5'd16;
	localparam logic [3:0] OP_PUSH = 4'd15;

	// Slot units per template, LUNIT stands for any memory slot
	localparam unit_t TEMPLATE_UNITS [NUM_TEMPLATES][NUM_SLOTS] = '{
		'{LUNIT, IUNIT, IUNIT},
		'{LUNIT, LUNIT, IUNIT},
		'{LUNIT, FUNIT, IUNIT},
		'{LUNIT, IUNIT, BUNIT},
		'{LUNIT, BUNIT, BUNIT},
		'{BUNIT, BUNIT, BUNIT},
		'{LUNIT, LUNIT, FUNIT},
		'{LUNIT, FUNIT, BUNIT}
	};

	// ==========================================================================
	// Decode word layout, unit in the top bits down to oddball in bit 0
	// ==========================================================================
	localparam int DW_UNIT_LO = 24;
	localparam int DW_RT_LO = 17;
	localparam int DW_MEMSZ_LO = 14;
	localparam int DW_HASCONST = 13;
	localparam int DW_ISLOAD = 12;
	localparam int DW_ISSTORE = 11;
	localparam int DW_ISBRANCH = 10;
	localparam int DW_ISJAL = 9;
	localparam int DW_ISRET = 8;
	localparam int DW_ISBRK = 7;
	localparam int DW_ISRTI = 6;
	localparam int DW_BTUPDATE = 5;
	localparam int DW_CANEXCEPT = 4;
	localparam int DW_RFW = 3;
	localparam int DW_PRELOAD = 2;
	localparam int DW_SYNC = 1;
	localparam int DW_ODDBALL = 0;

endpackage

//--- slotIf.sv
// One instruction slot between the unpacker, its decoder and the output latch.
// Purely combinational signals, no clock travels on this interface.
// The unpacker drives instr and unit, the decoder drives dec and imm.
`timescale 1ns/10ps

interface slotIf;

	// From templateUnpack
	decodePkg::instr_t instr;
	decodePkg::unit_t unit;

	// From instrDecoder
	decodePkg::decodeWord_t dec;
	decodePkg::const_t imm;

	modport unpack
	(
		output instr,
		output unit
	);

	modport decoder
	(
		input instr,
		input unit,
		output dec,
		output imm
	);

	modport latch
	(
		input dec,
		input imm
	);

endinterface

//--- templateUnpack.sv
// Splits a bundle into its three slots and assigns each slot a unit.
// Combinational, zero cycles.
// Memory slots become SUNIT when the slot's store bit is set, else LUNIT.
// An illegal template (8 to 31) gives every slot NONE and raises illegal,
// the slot instructions are still passed on unchanged.
`timescale 1ns/10ps

module templateUnpack
(
	input decodePkg::bundle_t bundle,
	output logic illegal,
	slotIf.unpack s0,
	slotIf.unpack s1,
	slotIf.unpack s2
);

	decodePkg::template_t tmpl;
	decodePkg::instr_t slotInstr [decodePkg::NUM_SLOTS];
	decodePkg::unit_t slotUnit [decodePkg::NUM_SLOTS];

	assign tmpl = bundle[decodePkg::TEMPLATE_HI:decodePkg::TEMPLATE_LO];
	assign illegal = tmpl >= decodePkg::template_t'(decodePkg::NUM_TEMPLATES);

	// ==========================================================================
	// Slot split and unit lookup
	// ==========================================================================
	always_comb
	begin
		for (int i = 0; i < decodePkg::NUM_SLOTS; i++)
		begin
			slotInstr[i] = bundle[decodePkg::SLOT_LO[i] +: decodePkg::INSTR_W];
			if (illegal)
			begin
				slotUnit[i] = decodePkg::NONE;
			end
			else
			begin
				slotUnit[i] = decodePkg::TEMPLATE_UNITS[tmpl[2:0]][i];
				// Table only says "memory", the store bit picks the direction
				if (slotUnit[i] == decodePkg::LUNIT && slotInstr[i][decodePkg::STOREBIT])
				begin
					slotUnit[i] = decodePkg::SUNIT;
				end
			end
		end
	end

	assign s0.instr = slotInstr[0];
	assign s0.unit = slotUnit[0];
	assign s1.instr = slotInstr[1];
	assign s1.unit = slotUnit[1];
	assign s2.instr = slotInstr[2];
	assign s2.unit = slotUnit[2];

	// A legal template never leaves a slot without a unit
	always_comb
	begin
		assert final (illegal
			|| (slotUnit[0] != decodePkg::NONE
			&& slotUnit[1] != decodePkg::NONE
			&& slotUnit[2] != decodePkg::NONE))
		else
			$error("templateUnpack: legal template %0d left a slot with unit NONE", tmpl);
	end

endmodule

//--- instrDecoder.sv
// Combinational decode of one slot into a decode word and a 64-bit constant.
// The register target comes from the instruction's RD field, never from outside.
// Unit NONE gives an all-zero word and constant, debugOn included.
// memSize is only meaningful for memory slots and reads zero elsewhere.
// Constants are sign-extended from bit 39 of the instruction.
`timescale 1ns/10ps

module instrDecoder
(
	input logic debugOn,
	slotIf.decoder slot
);

	decodePkg::instr_t instr;
	decodePkg::unit_t unit;
	logic [decodePkg::OP4_HI-decodePkg::OP4_LO:0] op4;
	logic [decodePkg::RD_HI-decodePkg::RD_LO:0] rd;
	logic [decodePkg::FUNCT5_HI-decodePkg::FUNCT5_LO:0] funct5;

	// Unit qualifiers
	logic isB;
	logic isI;
	logic isF;
	logic isLd;
	logic isSt;
	logic isMem;

	// Instruction qualifiers
	logic isPush;
	logic isJal;
	logic isRet;
	logic isBrk;
	logic isRtiGrp;
	logic isRti;
	logic isSei;
	logic isSyncOp;
	logic isChk;
	logic isChki;
	logic isCondBr;
	logic isR3;
	logic isMulDiv;
	logic isFsync;

	decodePkg::regTgt_t rt;
	decodePkg::memSize_t memSize;
	decodePkg::decodeWord_t dec;
	decodePkg::const_t imm;

	assign instr = slot.instr;
	assign unit = slot.unit;
	assign op4 = instr[decodePkg::OP4_HI:decodePkg::OP4_LO];
	assign rd = instr[decodePkg::RD_HI:decodePkg::RD_LO];
	assign funct5 = instr[decodePkg::FUNCT5_HI:decodePkg::FUNCT5_LO];

	assign isB = unit == decodePkg::BUNIT;
	assign isI = unit == decodePkg::IUNIT;
	assign isF = unit == decodePkg::FUNIT;
	assign isLd = unit == decodePkg::LUNIT;
	assign isSt = unit == decodePkg::SUNIT;
	assign isMem = isLd || isSt;

	// ==========================================================================
	// Opcode recognition
	// ==========================================================================
	// PUSH may arrive as a load or a store slot
	assign isPush = isMem && op4 == decodePkg::OP_PUSH;
	assign isJal = isB && op4 == decodePkg::OP_JAL;
	assign isRet = isB && op4 == decodePkg::OP_RET;
	assign isBrk = isB && op4 == decodePkg::OP_BRK;
	assign isRtiGrp = isB && op4 == decodePkg::OP_RTI;
	assign isRti = isRtiGrp && funct5 == decodePkg::FN_RTI;
	assign isSei = isRtiGrp && funct5 == decodePkg::FN_SEI;
	assign isSyncOp = isRtiGrp && funct5 == decodePkg::FN_SYNC;
	assign isChk = isB && op4 == decodePkg::OP_CHK;
	assign isChki = isB && op4 == decodePkg::OP_CHKI;
	assign isCondBr = isB && (op4 == decodePkg::OP_BEQ || op4 == decodePkg::OP_BNE
		|| op4 == decodePkg::OP_BLT || op4 == decodePkg::OP_BGE
		|| op4 == decodePkg::OP_BBC);
	assign isR3 = isI && op4 == decodePkg::OP_R3;
	assign isMulDiv = isI && (op4 == decodePkg::OP_MULI || op4 == decodePkg::OP_DIVI);
	assign isFsync = isF && op4 == decodePkg::OP_FLT2 && funct5 == decodePkg::FN_FSYNC;

	// Register target, float file flagged in bit 6
	always_comb
	begin
		if (isF)
			rt = {1'b1, rd};
		else if (isI || isLd || isPush || isJal || isRet || isSei)
			rt = {1'b0, rd};
		else
			rt = '0;
	end

	// Size codes 0 to 4 match the op4 low bits, the rest is deci
	always_comb
	begin
		memSize = '0;
		if (isMem)
		begin
			case (op4[2:0])
				decodePkg::SZ_BYTE,
				decodePkg::SZ_WYDE,
				decodePkg::SZ_TETRA,
				decodePkg::SZ_OCTA:
					memSize = op4[2:0];
				default:
					memSize = decodePkg::SZ_DECI;
			endcase
		end
	end

	// Constant field layout depends on the slot kind
	always_comb
	begin
		if (isLd)
			imm = {{44{instr[39]}}, instr[39:35], instr[30:16]};
		else if (isSt || isChki)
			imm = {{44{instr[39]}}, instr[39:35], instr[30:22], instr[5:0]};
		else if (unit != decodePkg::NONE)
			imm = {{42{instr[39]}}, instr[39:33], instr[30:16]};
		else
			imm = '0;
	end

	// ==========================================================================
	// Decode word
	// ==========================================================================
	always_comb
	begin
		dec = '0;
		if (unit != decodePkg::NONE)
		begin
			dec[decodePkg::DW_UNIT_LO +: decodePkg::UNIT_W] = unit;
			dec[decodePkg::DW_RT_LO +: decodePkg::RT_W] = rt;
			dec[decodePkg::DW_MEMSZ_LO +: decodePkg::MEMSZ_W] = memSize;
			// Only CHKI and JAL carry a constant among B-unit ops
			dec[decodePkg::DW_HASCONST] = !isR3 && !isPush && !(isB && !isChki && !isJal);
			dec[decodePkg::DW_ISLOAD] = isLd;
			dec[decodePkg::DW_ISSTORE] = isSt;
			dec[decodePkg::DW_ISBRANCH] = isCondBr;
			dec[decodePkg::DW_ISJAL] = isJal;
			dec[decodePkg::DW_ISRET] = isRet;
			dec[decodePkg::DW_ISBRK] = isBrk;
			dec[decodePkg::DW_ISRTI] = isRti;
			// Targets the branch predictor cannot know ahead of time
			dec[decodePkg::DW_BTUPDATE] = isJal || isRet || isBrk || isRti;
			dec[decodePkg::DW_CANEXCEPT] = debugOn || isBrk || isChk || isChki
				|| isMulDiv || isMem;
			dec[decodePkg::DW_RFW] = rt != '0 && !isFsync;
			dec[decodePkg::DW_PRELOAD] = isLd && rd == '0;
			dec[decodePkg::DW_SYNC] = isSyncOp || isRti || isBrk;
			dec[decodePkg::DW_ODDBALL] = isRti || isSei || isF;
		end
	end

	assign slot.dec = dec;
	assign slot.imm = imm;

	always_comb
	begin
		assert final (!(slot.dec[decodePkg::DW_ISLOAD] && slot.dec[decodePkg::DW_ISSTORE]))
		else
			$error("instrDecoder: slot decoded as both load and store");
	end

endmodule

//--- decodeLatch.sv
// Single register stage holding one decoded bundle for issue.
// A bundle is taken on a rising edge with bundleValid high and stall low.
// While stall is high every output holds and the inputs are ignored,
// so the source has to keep its bundle steady until it is taken.
// Only decValid and illegal are reset; the words and constants are not.
`timescale 1ns/10ps

module decodeLatch
(
	input logic clk,
	input logic reset,
	input logic bundleValid,
	input logic stall,
	input logic illegalIn,
	slotIf.latch s0,
	slotIf.latch s1,
	slotIf.latch s2,
	output logic decValid,
	output logic illegal,
	output decodePkg::decodeWord_t slot0Dec,
	output decodePkg::decodeWord_t slot1Dec,
	output decodePkg::decodeWord_t slot2Dec,
	output decodePkg::const_t slot0Imm,
	output decodePkg::const_t slot1Imm,
	output decodePkg::const_t slot2Imm
);

	logic take;

	assign take = bundleValid && !stall;

	// ==========================================================================
	// Control state
	// ==========================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			decValid <= 1'b0;
			illegal <= 1'b0;
		end
		else if (!stall)
		begin
			// An idle cycle empties the stage
			decValid <= bundleValid;
			illegal <= bundleValid && illegalIn;
		end
	end

	// Payload, loaded only on a take
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			slot0Dec <= s0.dec;
			slot1Dec <= s1.dec;
			slot2Dec <= s2.dec;
			slot0Imm <= s0.imm;
			slot1Imm <= s1.imm;
			slot2Imm <= s2.imm;
		end
	end

	// ==========================================================================
	// Checks
	// ==========================================================================
	assert property (@(posedge clk) reset |=> !decValid)
	else
		$error("decodeLatch: decValid high in the cycle after reset");

endmodule

//--- bundleDecoder.sv
// Decode stage top level: unpack, three slot decoders and one output register.
// Latency is one cycle from a take to decValid, the stage holds one bundle.
// There is no handshake; stall holds the outputs and the source must hold
// its bundle. debugOn marks every decoded slot as able to raise an exception.
`timescale 1ns/10ps

module bundleDecoder
(
	input logic clk,
	input logic reset,
	input logic bundleValid,
	input decodePkg::bundle_t bundle,
	input logic stall,
	input logic debugOn,
	output logic decValid,
	output logic illegal,
	output decodePkg::decodeWord_t slot0Dec,
	output decodePkg::decodeWord_t slot1Dec,
	output decodePkg::decodeWord_t slot2Dec,
	output decodePkg::const_t slot0Imm,
	output decodePkg::const_t slot1Imm,
	output decodePkg::const_t slot2Imm
);

	logic tmplIllegal;

	slotIf slot0Bus ();
	slotIf slot1Bus ();
	slotIf slot2Bus ();

	templateUnpack tmplUnpack
	(
		.bundle(bundle),
		.illegal(tmplIllegal),
		.s0(slot0Bus),
		.s1(slot1Bus),
		.s2(slot2Bus)
	);

	// One decoder per slot
	instrDecoder slotDec0
	(
		.debugOn(debugOn),
		.slot(slot0Bus)
	);

	instrDecoder slotDec1
	(
		.debugOn(debugOn),
		.slot(slot1Bus)
	);

	instrDecoder slotDec2
	(
		.debugOn(debugOn),
		.slot(slot2Bus)
	);

	decodeLatch outLatch
	(
		.clk(clk),
		.reset(reset),
		.bundleValid(bundleValid),
		.stall(stall),
		.illegalIn(tmplIllegal),
		.s0(slot0Bus),
		.s1(slot1Bus),
		.s2(slot2Bus),
		.decValid(decValid),
		.illegal(illegal),
		.slot0Dec(slot0Dec),
		.slot1Dec(slot1Dec),
		.slot2Dec(slot2Dec),
		.slot0Imm(slot0Imm),
		.slot1Imm(slot1Imm),
		.slot2Imm(slot2Imm)
	);

endmodule

//--- bundleDecoderTb.sv
// Directed testbench for the bundle decode stage.
// Expected words come from a reference model of the decode rules below.
// Inputs change 2 ns after a rising edge and outputs are sampled at the same point.
// Random slots use a 32-bit Fibonacci LFSR, stepped once per bit taken.
// The watchdog allows 60 cycles per bundle sent plus 200.
`timescale 1ns/10ps

module bundleDecoderTb;

	logic clk;
	logic reset;
	logic bundleValid;
	decodePkg::bundle_t bundle;
	logic stall;
	logic debugOn;
	logic decValid;
	logic illegal;
	decodePkg::decodeWord_t slot0Dec;
	decodePkg::decodeWord_t slot1Dec;
	decodePkg::decodeWord_t slot2Dec;
	decodePkg::const_t slot0Imm;
	decodePkg::const_t slot1Imm;
	decodePkg::const_t slot2Imm;

	int errorCount = 0;
	int checkCount = 0;
	int bundlesSent = 0;
	int cycleCount = 0;
	logic [31:0] lfsrState = 32'he0e34883;

	decodePkg::decodeWord_t gotDec [3];
	decodePkg::const_t gotImm [3];

	assign gotDec[0] = slot0Dec;
	assign gotDec[1] = slot1Dec;
	assign gotDec[2] = slot2Dec;
	assign gotImm[0] = slot0Imm;
	assign gotImm[1] = slot1Imm;
	assign gotImm[2] = slot2Imm;

	bundleDecoder dut_i
	(
		.clk(clk),
		.reset(reset),
		.bundleValid(bundleValid),
		.bundle(bundle),
		.stall(stall),
		.debugOn(debugOn),
		.decValid(decValid),
		.illegal(illegal),
		.slot0Dec(slot0Dec),
		.slot1Dec(slot1Dec),
		.slot2Dec(slot2Dec),
		.slot0Imm(slot0Imm),
		.slot1Imm(slot1Imm),
		.slot2Imm(slot2Imm)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==========================================================================
	// Random source and stimulus builders
	// ==========================================================================
	// Taps 32, 22, 2, 1
	function automatic logic [63:0] randBits(input int n);
		logic [63:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[62:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic decodePkg::instr_t makeInstr(input logic [3:0] op4, input logic [4:0] fn,
		input logic rdZero, input logic storeBit);
		decodePkg::instr_t v;
		v = decodePkg::instr_t'(randBits(40));
		v[9:6] = op4;
		v[26:22] = fn;
		v[34] = storeBit;
		if (rdZero)
			v[5:0] = 6'd0;
		return v;
	endfunction

	function automatic decodePkg::bundle_t randomBundle(input decodePkg::template_t t);
		logic [63:0] pad;
		logic [119:0] slots;
		slots = {decodePkg::instr_t'(randBits(40)), decodePkg::instr_t'(randBits(40)),
			decodePkg::instr_t'(randBits(40))};
		pad = randBits(3);
		return {pad[2:0], slots, t};
	endfunction

	// ==========================================================================
	// Reference model
	// ==========================================================================
	// Units per template as M(emory), I, F, B for slots 0, 1, 2
	function automatic decodePkg::unit_t expUnit(input decodePkg::template_t t, input int slot,
		input logic storeBit);
		logic [23:0] row;
		logic [7:0] c;
		case (t)
			5'd0: row = "MII";
			5'd1: row = "MMI";
			5'd2: row = "MFI";
			5'd3: row = "MIB";
			5'd4: row = "MBB";
			5'd5: row = "BBB";
			5'd6: row = "MMF";
			5'd7: row = "MFB";
			default: row = "---";
		endcase
		c = row[8*(2-slot) +: 8];
		if (c == "M")
			return storeBit ? decodePkg::SUNIT : decodePkg::LUNIT;
		else if (c == "I")
			return decodePkg::IUNIT;
		else if (c == "F")
			return decodePkg::FUNIT;
		else if (c == "B")
			return decodePkg::BUNIT;
		return decodePkg::NONE;
	endfunction

	function automatic void refDecode(input decodePkg::unit_t u, input decodePkg::instr_t ins,
		input logic dbg, output decodePkg::decodeWord_t dw, output decodePkg::const_t imm);
		logic [3:0] op4;
		logic [5:0] rd;
		logic [4:0] fn;
		logic b, i, f, ld, st, mem, push, jal, ret, brk, rti, sei, syncOp, chk, chki, cond;
		logic hasConst, btu, cex, rfw, pre, syn, odd;
		logic [6:0] rt;
		decodePkg::memSize_t ms;
		logic [19:0] f20;
		logic [21:0] f22;
		dw = '0;
		imm = '0;
		if (u == decodePkg::NONE)
			return;
		op4 = ins[9:6];
		rd = ins[5:0];
		fn = ins[26:22];
		b = u == decodePkg::BUNIT;
		i = u == decodePkg::IUNIT;
		f = u == decodePkg::FUNIT;
		ld = u == decodePkg::LUNIT;
		st = u == decodePkg::SUNIT;
		mem = ld || st;
		push = mem && op4 == 4'd15;
		jal = b && op4 == 4'd2;
		ret = b && op4 == 4'd3;
		brk = b && op4 == 4'd5;
		rti = b && op4 == 4'd8 && fn == 5'd0;
		sei = b && op4 == 4'd8 && fn == 5'd1;
		syncOp = b && op4 == 4'd8 && fn == 5'd3;
		chk = b && op4 == 4'd10;
		chki = b && op4 == 4'd11;
		cond = b && (op4 == 4'd0 || op4 == 4'd1 || op4 == 4'd4 || op4 == 4'd6 || op4 == 4'd7);

		if (f)
			rt = {1'b1, rd};
		else if (i || ld || push || jal || ret || sei)
			rt = {1'b0, rd};
		else
			rt = 7'd0;
		// FSYNC never writes back
		rfw = rt != 7'd0 && !(f && op4 == 4'd1 && fn == 5'd16);
		pre = ld && rd == 6'd0;

		if (!mem)
			ms = '0;
		else if (push)
			ms = decodePkg::SZ_DECI;
		else
		begin
			case (op4[2:0])
				3'd0: ms = decodePkg::SZ_BYTE;
				3'd1: ms = decodePkg::SZ_WYDE;
				3'd2: ms = decodePkg::SZ_TETRA;
				3'd4: ms = decodePkg::SZ_OCTA;
				default: ms = decodePkg::SZ_DECI;
			endcase
		end

		if (ld)
		begin
			f20 = {ins[39:35], ins[30:16]};
			imm = {{44{f20[19]}}, f20};
		end
		else if (st || chki)
		begin
			f20 = {ins[39:35], ins[30:22], ins[5:0]};
			imm = {{44{f20[19]}}, f20};
		end
		else
		begin
			f22 = {ins[39:33], ins[30:16]};
			imm = {{42{f22[21]}}, f22};
		end

		hasConst = !(i && op4 == 4'd2) && !push && !(b && !chki && !jal);
		btu = jal || ret || brk || rti;
		cex = dbg || brk || chk || chki || (i && (op4 == 4'd12 || op4 == 4'd13)) || mem;
		syn = syncOp || rti || brk;
		odd = rti || sei || f;
		dw = {u, rt, ms, hasConst, ld, st, cond, jal, ret, brk, rti, btu, cex, rfw, pre, syn, odd};
	endfunction

	// ==========================================================================
	// Checking and driving
	// ==========================================================================
	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		checkCount++;
		assert (got === expected)
		else
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic checkOutputs(input decodePkg::bundle_t b, input logic dbg);
		decodePkg::instr_t ins;
		decodePkg::unit_t u;
		decodePkg::decodeWord_t expDec;
		decodePkg::const_t expImm;
		checkValue("decValid", 64'(decValid), 64'd1);
		checkValue("illegal", 64'(illegal), 64'(b[4:0] > 5'd7));
		for (int s = 0; s < 3; s++)
		begin
			ins = b[5 + 40*s +: 40];
			u = expUnit(b[4:0], s, ins[34]);
			refDecode(u, ins, dbg, expDec, expImm);
			checkValue($sformatf("slot%0dDec", s), 64'(gotDec[s]), 64'(expDec));
			checkValue($sformatf("slot%0dImm", s), gotImm[s], expImm);
		end
	endtask

	// Offer one bundle, check it one cycle after the take
	task automatic takeBundle(input decodePkg::bundle_t b, input logic dbg);
		bundle = b;
		debugOn = dbg;
		bundleValid = 1'b1;
		stall = 1'b0;
		bundlesSent++;
		@(posedge clk);
		#2;
		bundleValid = 1'b0;
		checkOutputs(b, dbg);
	endtask

	// Same op4 in all three slots, op4 0 to 15
	task automatic sweepOps(input decodePkg::template_t t, input logic [4:0] fn,
		input logic rdZero, input logic storeBit, input logic dbg);
		decodePkg::instr_t s0, s1, s2;
		logic [63:0] pad;
		for (int op = 0; op < 16; op++)
		begin
			s0 = makeInstr(4'(op), fn, rdZero, storeBit);
			s1 = makeInstr(4'(op), fn, rdZero, storeBit);
			s2 = makeInstr(4'(op), fn, rdZero, storeBit);
			pad = randBits(3);
			takeBundle({pad[2:0], s2, s1, s0, t}, dbg);
		end
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================
	task automatic templateMapping();
		for (int t = 0; t < 32; t++)
			takeBundle(randomBundle(5'(t)), 1'b0);
	endtask

	task automatic registerTargets();
		decodePkg::template_t tList [5] = '{5'd0, 5'd2, 5'd3, 5'd5, 5'd6};
		for (int k = 0; k < 5; k++)
		begin
			sweepOps(tList[k], 5'd16, 1'b0, 1'b0, 1'b0);
			sweepOps(tList[k], 5'd1, 1'b1, 1'b1, 1'b0);
			sweepOps(tList[k], 5'd1, 1'b0, 1'b1, 1'b0);
		end
	endtask

	task automatic branchUnitFlags();
		for (int fn = 0; fn < 4; fn++)
		begin
			sweepOps(5'd5, 5'(fn), 1'b0, 1'b0, 1'b0);
			sweepOps(5'd7, 5'(fn), 1'b0, 1'b1, 1'b1);
		end
		sweepOps(5'd0, 5'd0, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic memSizeAndConst();
		sweepOps(5'd1, 5'd0, 1'b0, 1'b0, 1'b0);
		sweepOps(5'd1, 5'd0, 1'b0, 1'b1, 1'b0);
		sweepOps(5'd6, 5'd2, 1'b1, 1'b0, 1'b0);
		sweepOps(5'd6, 5'd2, 1'b0, 1'b1, 1'b0);
		sweepOps(5'd4, 5'd0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic stallAndIdle();
		decodePkg::bundle_t held;
		held = randomBundle(5'd3);
		// Idle cycle empties the stage
		bundleValid = 1'b0;
		stall = 1'b0;
		@(posedge clk);
		#2;
		checkValue("decValid", 64'(decValid), 64'd0);
		// Stalled offer into an empty stage is not taken
		bundle = held;
		debugOn = 1'b0;
		bundleValid = 1'b1;
		stall = 1'b1;
		@(posedge clk);
		#2;
		checkValue("decValid", 64'(decValid), 64'd0);
		stall = 1'b0;
		bundlesSent++;
		@(posedge clk);
		#2;
		checkOutputs(held, 1'b0);
		// Outputs hold while the input wanders
		stall = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			bundle = randomBundle(5'(randBits(5)));
			debugOn = 1'(k);
			@(posedge clk);
			#2;
			checkOutputs(held, 1'b0);
		end
		stall = 1'b0;
		bundleValid = 1'b0;
		@(posedge clk);
		#2;
		checkValue("decValid", 64'(decValid), 64'd0);
		// Idle cycle after an illegal bundle clears illegal
		takeBundle(randomBundle(5'd20), 1'b0);
		@(posedge clk);
		#2;
		checkValue("decValid", 64'(decValid), 64'd0);
		checkValue("illegal", 64'(illegal), 64'd0);
		// Reset while holding a bundle
		takeBundle(randomBundle(5'd25), 1'b1);
		reset = 1'b1;
		@(posedge clk);
		#2;
		reset = 1'b0;
		checkValue("decValid", 64'(decValid), 64'd0);
		checkValue("illegal", 64'(illegal), 64'd0);
	endtask

	initial
	begin
		while (cycleCount <= 60*bundlesSent + 200)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Watchdog expired after %0d cycles with %0d bundles sent", cycleCount,
			bundlesSent);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		bundleValid = 1'b0;
		bundle = '0;
		stall = 1'b0;
		debugOn = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		checkValue("decValid", 64'(decValid), 64'd0);
		checkValue("illegal", 64'(illegal), 64'd0);
		templateMapping();
		registerTargets();
		branchUnitFlags();
		memSizeAndConst();
		stallAndIdle();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- sources.f
decodePkg.sv
slotIf.sv
templateUnpack.sv
instrDecoder.sv
decodeLatch.sv
bundleDecoder.sv
bundleDecoderTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the bundle decoder testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module bundleDecoderTb \
	-f sources.f \
	-o VbundleDecoderTb

./obj_dir/VbundleDecoderTb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
